// File: src/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// matrix unit result rows
`define LSU_ROWS 16

// one row of int8 results fills one bank word
`define LSU_WORD_W 128
`define LSU_BYTES 16

// bank geometry
`define LSU_DEPTH 256
`define LSU_ADDR_W 8

// readback port
`define LSU_APB_AW 14
`define LSU_APB_DW 32

`endif

// File: src/lsu_pkg.sv
`include "lsu_macros.svh"

package lsu_pkg;

    // target bank of a store, code 3 is reserved
    typedef enum logic [1:0] {
        BANK_IRAM = 2'd0,
        BANK_WRAM = 2'd1,
        BANK_ORAM = 2'd2,
        BANK_NONE = 2'd3
    } bank_e;

    typedef logic [$clog2(`LSU_ROWS)-1:0] row_idx_t;
    typedef logic [`LSU_ADDR_W-1:0] word_addr_t;
    typedef logic [`LSU_WORD_W-1:0] word_t;
    typedef logic [`LSU_BYTES-1:0] byte_en_t;

    // window width is 8 << code bits, codes above 4 give the whole row
    typedef logic [2:0] len_code_t;

    // sequencer to row mask
    typedef struct packed {
        row_idx_t   row;
        word_addr_t addr;
        bank_e      bank;
        logic [3:0] start_x;
        len_code_t  len;
    } seq_beat_t;

    // row mask to banks
    typedef struct packed {
        word_addr_t addr;
        bank_e      bank;
        word_t      data;
        byte_en_t   byte_en;
    } wr_beat_t;

    // [13:12] bank, [11:4] word, [3:2] 32-bit lane
    typedef logic [`LSU_APB_AW-1:0] apb_addr_t;

endpackage

// File: src/lsu_beat_if.sv
`timescale 1ns/1ns

// one pipeline beat per cycle with valid high
// there is no ready since the banks never stall a write
interface lsu_beat_if #(
    parameter type T = logic
) ();

    logic valid;
    T     payload;
    logic last;

    modport source (
        output valid,
        output payload,
        output last
    );

    modport sink (
        input valid,
        input payload,
        input last
    );

endinterface

// File: src/lsu_st_seq.sv
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_st_seq import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       st_valid,
    output logic       st_ready,
    input  bank_e      st_bank,
    input  logic [3:0] st_start_x,
    input  row_idx_t   st_start_y,
    input  logic [4:0] st_num,
    input  len_code_t  st_len,
    input  word_addr_t st_addr,
    input  logic       mxu_data_rdy,
    lsu_beat_if.source seq
);

    logic       busy;
    logic       accept;
    logic       issue;
    logic       last_beat;

    // captured instruction and running counters
    logic [4:0] left_q;
    row_idx_t   row_q;
    word_addr_t addr_q;
    bank_e      bank_q;
    logic [3:0] start_x_q;
    len_code_t  len_q;

    assign accept    = st_valid & st_ready;
    assign st_ready  = ~busy;
    assign issue     = busy & mxu_data_rdy;
    assign last_beat = (left_q == 5'd1);

    // busy from acceptance until the last beat goes out
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (issue && last_beat) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            left_q    <= st_num;
            row_q     <= st_start_y;
            addr_q    <= st_addr;
            bank_q    <= st_bank;
            start_x_q <= st_start_x;
            len_q     <= st_len;
        end else if (issue) begin
            left_q <= left_q - 5'd1;
            // rows wrap mod 16 and words mod 256 by width
            row_q  <= row_q + 1'b1;
            addr_q <= addr_q + 1'b1;
        end
    end

    // a beat goes out in every cycle the matrix unit has data
    assign seq.valid = issue;
    assign seq.last  = last_beat;
    assign seq.payload = '{
        row:     row_q,
        addr:    addr_q,
        bank:    bank_q,
        start_x: start_x_q,
        len:     len_q
    };

    // host never sends an empty store, an oversized one or the reserved bank
    a_legal_store: assert property (@(posedge clk) disable iff (rst)
        accept |-> (st_bank != BANK_NONE) && (st_num != 5'd0)
                   && (st_num <= 5'(`LSU_ROWS)));

endmodule

// File: src/lsu_row_mask.sv
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_row_mask import lsu_pkg::*; (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [`LSU_ROWS*`LSU_WORD_W-1:0] mxu_rows,
    lsu_beat_if.sink                         seq,
    lsu_beat_if.source                       wr
);

    word_t      row_data;
    logic [4:0] win_bytes;
    logic [5:0] win_end;
    byte_en_t   be;
    word_t      win_data;

    // window width in bytes for a length code
    function automatic logic [4:0] len_to_bytes(len_code_t code);
        if (code <= 3'd4) begin
            return 5'(1 << code);
        end
        return 5'(`LSU_BYTES);
    endfunction

    always_comb begin
        row_data  = mxu_rows[seq.payload.row * `LSU_WORD_W +: `LSU_WORD_W];
        win_bytes = len_to_bytes(seq.payload.len);
        // one past the last byte and may run beyond byte 15
        win_end   = {2'b00, seq.payload.start_x} + {1'b0, win_bytes};
        for (int i = 0; i < `LSU_BYTES; i++) begin
            be[i] = (i >= int'(seq.payload.start_x)) && (i < int'(win_end));
            win_data[i*8 +: 8] = be[i] ? row_data[i*8 +: 8] : 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr.valid <= 1'b0;
        end else begin
            wr.valid <= seq.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (seq.valid) begin
            wr.last <= seq.last;
            wr.payload <= '{
                addr:    seq.payload.addr,
                bank:    seq.payload.bank,
                data:    win_data,
                byte_en: be
            };
        end
    end

    // every write beat touches at least one byte
    a_be_nonzero: assert property (@(posedge clk) disable iff (rst)
        wr.valid |-> (wr.payload.byte_en != '0));

endmodule

// File: src/lsu_sram_banks.sv
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_sram_banks import lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    lsu_beat_if.sink               wr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  apb_addr_t              paddr,
    input  logic [`LSU_APB_DW-1:0] pwdata,
    output logic [`LSU_APB_DW-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr
);

    localparam int NBANKS = 3;
    localparam int LANES  = `LSU_WORD_W / `LSU_APB_DW;
    localparam int LANE_W = $clog2(LANES);

    bank_e             req_bank;
    word_addr_t        req_word;
    logic [LANE_W-1:0] req_lane;
    logic              access;
    logic              req_err;
    logic              bank_busy;
    logic              rd_fire;

    bank_e             rd_bank;
    logic [LANE_W-1:0] rd_lane;
    word_t             bank_q [NBANKS];
    word_t             rd_word;

    // apb address split
    assign req_bank = bank_e'(paddr[`LSU_APB_AW-1 -: 2]);
    assign req_word = paddr[`LSU_ADDR_W+3:4];
    assign req_lane = paddr[3:2];

    assign access    = psel & penable;
    assign req_err   = pwrite | (req_bank == BANK_NONE);
    // store beat owns the port of its bank this cycle
    assign bank_busy = wr.valid & (wr.payload.bank == req_bank);
    assign rd_fire   = access & ~pready & ~req_err & ~bank_busy;

    for (genvar b = 0; b < NBANKS; b++) begin : g_bank
        word_t ram [`LSU_DEPTH];
        word_t rd_q;
        logic  wr_hit;
        logic  rd_en;

        assign wr_hit = wr.valid & (wr.payload.bank == bank_e'(b));
        assign rd_en  = rd_fire & (req_bank == bank_e'(b));

        // single port with the write first
        always_ff @(posedge clk) begin
            if (wr_hit) begin
                for (int i = 0; i < `LSU_BYTES; i++) begin
                    if (wr.payload.byte_en[i]) begin
                        ram[wr.payload.addr][i*8 +: 8] <= wr.payload.data[i*8 +: 8];
                    end
                end
            end else if (rd_en) begin
                rd_q <= ram[req_word];
            end
        end

        assign bank_q[b] = rd_q;
    end

    // completion one cycle after the read issues or at once on an error
    always_ff @(posedge clk) begin
        if (rst) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            pready  <= access & ~pready & (req_err | ~bank_busy);
            pslverr <= access & ~pready & req_err;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_bank <= req_bank;
            rd_lane <= req_lane;
        end
    end

    always_comb begin
        rd_word = bank_q[rd_bank];
        prdata  = '0;
        if (pready && !pslverr) begin
            prdata = rd_word[rd_lane * `LSU_APB_DW +: `LSU_APB_DW];
        end
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (rst)
        penable |-> psel);

endmodule

// File: src/lsu_top.sv
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_top import lsu_pkg::*; (
    input  logic                             clk,
    input  logic                             rst,

    // store instruction
    input  logic                             st_valid,
    output logic                             st_ready,
    input  bank_e                            st_bank,
    input  logic [3:0]                       st_start_x,
    input  row_idx_t                         st_start_y,
    input  logic [4:0]                       st_num,
    input  len_code_t                        st_len,
    input  word_addr_t                       st_addr,

    // matrix unit results
    input  logic [`LSU_ROWS*`LSU_WORD_W-1:0] mxu_rows,
    input  logic                             mxu_data_rdy,

    // apb readback
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  apb_addr_t                        paddr,
    input  logic [`LSU_APB_DW-1:0]           pwdata,
    output logic [`LSU_APB_DW-1:0]           prdata,
    output logic                             pready,
    output logic                             pslverr
);

    lsu_beat_if #(.T(seq_beat_t)) seq_if ();
    lsu_beat_if #(.T(wr_beat_t))  wr_if ();

    lsu_st_seq u_st_seq (
        .clk          (clk),
        .rst          (rst),
        .st_valid     (st_valid),
        .st_ready     (st_ready),
        .st_bank      (st_bank),
        .st_start_x   (st_start_x),
        .st_start_y   (st_start_y),
        .st_num       (st_num),
        .st_len       (st_len),
        .st_addr      (st_addr),
        .mxu_data_rdy (mxu_data_rdy),
        .seq          (seq_if.source)
    );

    lsu_row_mask u_row_mask (
        .clk      (clk),
        .rst      (rst),
        .mxu_rows (mxu_rows),
        .seq      (seq_if.sink),
        .wr       (wr_if.source)
    );

    lsu_sram_banks u_sram_banks (
        .clk     (clk),
        .rst     (rst),
        .wr      (wr_if.sink),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

endmodule

// File: test/lsu_tb_model.svh
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

// reference copy of the three banks, one known bit per byte
word_t    mdl_mem   [3][`LSU_DEPTH];
byte_en_t mdl_known [3][`LSU_DEPTH];
int       checks = 0;
int       errors = 0;

// one store as the write rule describes it
task automatic model_store(input int bank, input int sx, input int sy, input int num,
                           input len_code_t len, input int addr,
                           input logic [`LSU_ROWS*`LSU_WORD_W-1:0] rows);
    int width_bits;
    int row;
    int wa;
    // codes above 4 keep the whole row
    width_bits = (len <= 3'd4) ? (8 << len) : `LSU_WORD_W;
    for (int k = 0; k < num; k++) begin
        row = (sy + k) % `LSU_ROWS;
        wa  = (addr + k) % `LSU_DEPTH;
        for (int i = sx; (i < sx + width_bits / 8) && (i < `LSU_BYTES); i++) begin
            mdl_mem[bank][wa][i*8 +: 8] = rows[row*`LSU_WORD_W + i*8 +: 8];
            mdl_known[bank][wa][i] = 1'b1;
        end
    end
endtask

// ones over every known byte of a 32-bit lane
function automatic logic [31:0] lane_care(input byte_en_t known, input int lane);
    logic [31:0] care;
    for (int i = 0; i < 4; i++) begin
        care[i*8 +: 8] = {8{known[lane*4 + i]}};
    end
    return care;
endfunction

task automatic check_word(input word_t got, input word_t exp, input byte_en_t care,
                          input string what);
    word_t mask;
    for (int i = 0; i < `LSU_BYTES; i++) begin
        mask[i*8 +: 8] = {8{care[i]}};
    end
    checks++;
    if ((got & mask) !== (exp & mask)) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h",
                 $time, what, got & mask, exp & mask);
    end
endtask

task automatic check_lane(input logic [31:0] got, input logic [31:0] exp,
                          input logic [31:0] care, input string what);
    checks++;
    if ((got & care) !== (exp & care)) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h",
                 $time, what, got & care, exp & care);
    end
endtask

task automatic check_err(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

`endif

// File: test/lsu_tb.sv
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int NSTORES = 40;

    typedef struct {
        bank_e      bank;
        logic [3:0] sx;
        row_idx_t   sy;
        logic [4:0] num;
        len_code_t  len;
        word_addr_t addr;
        logic [`LSU_ROWS*`LSU_WORD_W-1:0] rows;
    } store_t;

    logic clk;
    logic rst;
    logic st_valid;
    logic st_ready;
    bank_e st_bank;
    logic [3:0] st_start_x;
    row_idx_t st_start_y;
    logic [4:0] st_num;
    len_code_t st_len;
    word_addr_t st_addr;
    logic [`LSU_ROWS*`LSU_WORD_W-1:0] mxu_rows;
    logic mxu_data_rdy;
    logic psel;
    logic penable;
    logic pwrite;
    apb_addr_t paddr;
    logic [`LSU_APB_DW-1:0] pwdata;
    logic [`LSU_APB_DW-1:0] prdata;
    logic pready;
    logic pslverr;

    integer seed;
    int     cycles = 0;
    store_t stores [NSTORES];
    word_t    snap_mem   [3][`LSU_DEPTH];
    byte_en_t snap_known [3][`LSU_DEPTH];

    `include "lsu_tb_model.svh"

    lsu_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic apb_addr_t word_paddr(input int bank, input int addr, input int lane);
        return {bank[1:0], addr[7:0], lane[1:0], 2'b00};
    endfunction

    // setup phase, then access until pready
    task automatic apb_xfer(input apb_addr_t a, input logic wr,
                            output logic [31:0] data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = wr ? $random(seed) : '0;
        @(posedge clk);
        #2 penable = 1'b1;
        do begin
            @(posedge clk);
            #2;
        end while (!pready);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #2 psel = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_word(input int bank, input int addr, output word_t w);
        logic [31:0] data;
        logic err;
        for (int lane = 0; lane < 4; lane++) begin
            apb_xfer(word_paddr(bank, addr, lane), 1'b0, data, err);
            check_err(err, 1'b0, "pslverr on a bank read");
            w[lane*32 +: 32] = data;
        end
    endtask

    task automatic readback_word(input int bank, input int addr);
        word_t w;
        read_word(bank, addr, w);
        for (int lane = 0; lane < 4; lane++) begin
            check_lane(w[lane*32 +: 32], mdl_mem[bank][addr][lane*32 +: 32],
                       lane_care(mdl_known[bank][addr], lane),
                       $sformatf("bank %0d word %0d lane %0d", bank, addr, lane));
        end
    endtask

    task automatic random_store(output store_t s);
        s.bank = bank_e'(2'($unsigned($random(seed)) % 3));
        s.sx   = 4'($random(seed));
        s.sy   = row_idx_t'($random(seed));
        s.num  = 5'($unsigned($random(seed)) % 16 + 1);
        s.len  = len_code_t'($random(seed));
        s.addr = word_addr_t'($random(seed));
        for (int j = 0; j < `LSU_ROWS * `LSU_WORD_W / 32; j++) begin
            s.rows[j*32 +: 32] = $random(seed);
        end
    endtask

    // stall toggles mxu_data_rdy at random while the store runs
    task automatic run_store(input store_t s, input logic stall);
        while (!st_ready) begin
            @(posedge clk);
            #2;
        end
        st_valid     = 1'b1;
        st_bank      = s.bank;
        st_start_x   = s.sx;
        st_start_y   = s.sy;
        st_num       = s.num;
        st_len       = s.len;
        st_addr      = s.addr;
        mxu_rows     = s.rows;
        mxu_data_rdy = stall ? 1'($random(seed)) : 1'b1;
        @(posedge clk);
        #2 st_valid = 1'b0;
        while (!st_ready) begin
            if (stall) begin
                mxu_data_rdy = 1'($random(seed));
            end
            @(posedge clk);
            #2;
        end
        mxu_data_rdy = 1'b1;
        // last beat lands within three cycles
        repeat (3) @(posedge clk);
        #2;
        model_store(s.bank, s.sx, s.sy, s.num, s.len, s.addr, s.rows);
    endtask

    task automatic end_test(input string name, input int errs_before);
        $display("test %s finished, %0d checks so far, %0d new errors",
                 name, checks, errors - errs_before);
    endtask

    initial begin
        store_t s;
        word_t w;
        logic [31:0] data;
        logic err;
        int e0;
        seed = 32'hf01d_1099;
        st_valid = 1'b0;
        st_bank = BANK_IRAM;
        st_start_x = '0;
        st_start_y = '0;
        st_num = 5'd1;
        st_len = '0;
        st_addr = '0;
        mxu_rows = '0;
        mxu_data_rdy = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        mdl_known = '{default: '0};
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;

        e0 = errors;
        @(posedge clk);
        #2;
        check_err(st_ready, 1'b1, "st_ready after reset");
        check_err(pready, 1'b0, "pready after reset");
        end_test("reset_state", e0);

        e0 = errors;
        for (int n = 0; n < NSTORES; n++) begin
            random_store(stores[n]);
            run_store(stores[n], 1'b0);
            for (int k = 0; k < stores[n].num; k++) begin
                readback_word(stores[n].bank, (int'(stores[n].addr) + k) % `LSU_DEPTH);
            end
        end
        snap_mem = mdl_mem;
        snap_known = mdl_known;
        end_test("random_stores", e0);

        // overwrite every bank, then replay the same stores with stalls
        e0 = errors;
        for (int b = 0; b < 3; b++) begin
            for (int a = 0; a < `LSU_DEPTH; a += 16) begin
                s.bank = bank_e'(2'(b));
                s.sx = '0;
                s.sy = '0;
                s.num = 5'd16;
                s.len = 3'd7;
                s.addr = word_addr_t'(a);
                for (int r = 0; r < `LSU_ROWS; r++) begin
                    s.rows[r*`LSU_WORD_W +: `LSU_WORD_W] = {8{2'(b), 8'(a + r), 6'h2b}};
                end
                run_store(s, 1'b0);
            end
        end
        for (int n = 0; n < NSTORES; n++) begin
            run_store(stores[n], 1'b1);
        end
        for (int b = 0; b < 3; b++) begin
            for (int a = 0; a < `LSU_DEPTH; a++) begin
                if (snap_known[b][a] != '0) begin
                    read_word(b, a, w);
                    check_word(w, snap_mem[b][a], snap_known[b][a],
                               $sformatf("stalled replay bank %0d word %0d", b, a));
                end
            end
        end
        end_test("stalled_replay", e0);

        e0 = errors;
        random_store(s);
        for (int n = 0; n < 6; n++) begin
            random_store(stores[0]);
            stores[0].bank = s.bank;
            stores[0].addr = s.addr;
            stores[0].num = 5'd4;
            run_store(stores[0], 1'b0);
        end
        for (int k = 0; k < 4; k++) begin
            readback_word(s.bank, (int'(s.addr) + k) % `LSU_DEPTH);
        end
        end_test("overlap_windows", e0);

        e0 = errors;
        apb_xfer(word_paddr(s.bank, s.addr, 1), 1'b1, data, err);
        check_err(err, 1'b1, "pslverr on an apb write");
        check_lane(data, '0, '1, "prdata on an apb write");
        apb_xfer(word_paddr(3, s.addr, 0), 1'b0, data, err);
        check_err(err, 1'b1, "pslverr on the reserved bank");
        check_lane(data, '0, '1, "prdata on the reserved bank");
        readback_word(s.bank, s.addr);
        end_test("apb_errors", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+src
+incdir+test
src/lsu_pkg.sv
src/lsu_beat_if.sv
src/lsu_st_seq.sv
src/lsu_row_mask.sv
src/lsu_sram_banks.sv
src/lsu_top.sv
test/lsu_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f tb.f -o lsu_sim
out=$(./obj_dir/lsu_sim)
echo "$out"
if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
